/* cpu_backend.sv */
`default_nettype none // Catch any undeclared net as an error

module cpu_backend import cpu_pkg::*; (
  input  logic     clk,           // Core clock
  input  logic     arst_n,        // Asynchronous reset, active low
  input  word_t    ex_pc_next,    // Execute stage results
  input  word_t    ex_alu_out,
  input  word_t    ex_mem_wdata,
  input  logic     ex_mem_enable,
  input  logic     ex_mem_write,
  input  reg_idx_t ex_reg_rd,
  input  logic     ex_reg_write,
  input  logic     ex_mem_to_reg,
  input  logic     ex_hlt,
  input  logic     ex_pcs,
  output logic     stall,         // Execute must hold its outputs while high
  output word_t    paddr,         // APB requester
  output word_t    pwdata,
  output logic     pwrite,
  output logic     psel,
  output logic     penable,
  input  word_t    prdata,
  input  logic     pready,
  input  reg_idx_t rf_raddr,      // Register file read port
  output word_t    rf_rdata,
  output logic     wb_reg_write,  // Retire port
  output reg_idx_t wb_reg_rd,
  output word_t    wb_data,
  output logic     halted
);

  word_t    em_pc_next;    // EX/MEM contents
  word_t    em_alu_out;
  word_t    em_mem_wdata;
  logic     em_mem_enable;
  logic     em_mem_write;
  reg_idx_t em_reg_rd;
  logic     em_reg_write;
  logic     em_mem_to_reg;
  logic     em_hlt;
  logic     em_pcs;
  word_t    rdata;         // Load data out of the memory stage
  word_t    mw_pc_next;    // MEM/WB contents
  word_t    mw_alu_out;
  word_t    mw_rdata;
  reg_idx_t mw_reg_rd;
  logic     mw_reg_write;
  logic     mw_mem_to_reg;
  logic     mw_hlt;
  logic     mw_pcs;

  ex_mem_pipe_reg i_ex_mem_pipe_reg (
    .clk, .arst_n, .stall,
    .ex_pc_next, .ex_alu_out, .ex_mem_wdata, .ex_mem_enable, .ex_mem_write,
    .ex_reg_rd, .ex_reg_write, .ex_mem_to_reg, .ex_hlt, .ex_pcs,
    .em_pc_next, .em_alu_out, .em_mem_wdata, .em_mem_enable, .em_mem_write,
    .em_reg_rd, .em_reg_write, .em_mem_to_reg, .em_hlt, .em_pcs
  );

  // Memory stage owns the stall that holds EX/MEM and bubbles MEM/WB
  mem_access_apb i_mem_access_apb (
    .clk, .arst_n,
    .em_alu_out, .em_mem_wdata, .em_mem_enable, .em_mem_write,
    .prdata, .pready,
    .paddr, .pwdata, .pwrite, .psel, .penable,
    .stall, .rdata
  );

  mem_wb_pipe_reg i_mem_wb_pipe_reg (
    .clk, .arst_n, .stall,
    .em_pc_next, .em_alu_out, .em_reg_rd, .em_reg_write, .em_mem_to_reg,
    .em_hlt, .em_pcs, .rdata,
    .mw_pc_next, .mw_alu_out, .mw_rdata, .mw_reg_rd, .mw_reg_write,
    .mw_mem_to_reg, .mw_hlt, .mw_pcs
  );

  write_back i_write_back (
    .clk, .arst_n,
    .mw_pc_next, .mw_alu_out, .mw_rdata, .mw_reg_rd, .mw_reg_write,
    .mw_mem_to_reg, .mw_hlt, .mw_pcs,
    .rf_raddr, .rf_rdata,
    .wb_reg_write, .wb_reg_rd, .wb_data, .halted
  );

endmodule

`default_nettype wire // Back to the language default for later files

/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Data, address and PC words all share one width
`define CPU_WORD_W 16

// Register numbers select one of the register file entries
`define CPU_REG_IDX_W 4

////////////////////////////////////////
// Register file
////////////////////////////////////////

`define CPU_NUM_REGS 16 // Entry 0 is the hardwired zero register

`endif

/* cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

  ////////////////////////////////////////
  // Datapath types
  ////////////////////////////////////////

  // One data, address or PC word as seen anywhere in the back end
  typedef logic [`CPU_WORD_W-1:0] word_t;

  // Destination or read register number
  typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

  ////////////////////////////////////////
  // APB requester
  ////////////////////////////////////////

  // The requester idles in SETUP and raises psel there when a memory op arrives
  // ACCESS holds psel and penable high until the completer answers with pready
  typedef enum logic {
    SETUP,  // Idle or setup phase
    ACCESS  // Access phase, waiting on pready
  } apb_state_e;

endpackage

/* ex_mem_pipe_reg.sv */
`default_nettype none // Catch any undeclared net as an error

module ex_mem_pipe_reg import cpu_pkg::*; (
  input  logic     clk,           // Core clock
  input  logic     arst_n,        // Asynchronous reset, active low
  input  logic     stall,         // Memory stage busy, so hold the current contents
  input  word_t    ex_pc_next,    // Next PC carried along for PCS instructions
  input  word_t    ex_alu_out,    // ALU result, also the memory address
  input  word_t    ex_mem_wdata,  // Store data
  input  logic     ex_mem_enable, // Instruction accesses data memory
  input  logic     ex_mem_write,  // Memory access is a store
  input  reg_idx_t ex_reg_rd,     // Destination register
  input  logic     ex_reg_write,  // Instruction writes the register file
  input  logic     ex_mem_to_reg, // Write-back takes the load data
  input  logic     ex_hlt,        // Halt instruction
  input  logic     ex_pcs,        // Write-back takes the next PC
  output word_t    em_pc_next,
  output word_t    em_alu_out,
  output word_t    em_mem_wdata,
  output logic     em_mem_enable,
  output logic     em_mem_write,
  output reg_idx_t em_reg_rd,
  output logic     em_reg_write,
  output logic     em_mem_to_reg,
  output logic     em_hlt,
  output logic     em_pcs
);

  // A new instruction is taken only while the memory stage is free
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      em_pc_next    <= '0;
      em_alu_out    <= '0;
      ////////////////////////////////////////
      // Memory stage fields
      ////////////////////////////////////////
      em_mem_wdata  <= '0;
      em_mem_enable <= 1'b0;
      em_mem_write  <= 1'b0;
      ////////////////////////////////////////
      // Write-back stage fields
      ////////////////////////////////////////
      em_reg_rd     <= '0;
      em_reg_write  <= 1'b0;
      em_mem_to_reg <= 1'b0;
      em_hlt        <= 1'b0;
      em_pcs        <= 1'b0;
    end else if (!stall) begin
      em_pc_next    <= ex_pc_next;
      em_alu_out    <= ex_alu_out;    // Becomes paddr in the memory stage
      em_mem_wdata  <= ex_mem_wdata;  // Becomes pwdata in the memory stage
      em_mem_enable <= ex_mem_enable;
      em_mem_write  <= ex_mem_write;
      em_reg_rd     <= ex_reg_rd;
      em_reg_write  <= ex_reg_write;
      em_mem_to_reg <= ex_mem_to_reg;
      em_hlt        <= ex_hlt;
      em_pcs        <= ex_pcs;
    end
  end

  // A store that is not flagged as a memory access would never reach the bus
  a_write_needs_enable : assert property (@(posedge clk) disable iff (!arst_n)
    em_mem_write |-> em_mem_enable);

endmodule

`default_nettype wire // Back to the language default for later files

/* list.f */
+incdir+.
cpu_pkg.sv
ex_mem_pipe_reg.sv
mem_access_apb.sv
mem_wb_pipe_reg.sv
write_back.sv
cpu_backend.sv
tb_clock_gen.sv
tb_apb_mem.sv
tb_cpu_backend.sv

/* mem_access_apb.sv */
`default_nettype none // Catch any undeclared net as an error

module mem_access_apb import cpu_pkg::*; (
  input  logic  clk,           // Core clock
  input  logic  arst_n,        // Asynchronous reset, active low
  input  word_t em_alu_out,    // Address of the memory op
  input  word_t em_mem_wdata,  // Store data of the memory op
  input  logic  em_mem_enable, // A memory op sits in EX/MEM
  input  logic  em_mem_write,  // The op is a store
  input  word_t prdata,        // Read data from the completer
  input  logic  pready,        // Completer ends the access phase
  output word_t paddr,
  output word_t pwdata,
  output logic  pwrite,
  output logic  psel,
  output logic  penable,
  output logic  stall,         // Back-pressure for every stage in front of MEM/WB
  output word_t rdata          // Load data offered to MEM/WB
);

  apb_state_e state;     // Current bus phase
  apb_state_e state_nxt; // Phase for the next cycle

  logic done; // Access phase completes in this cycle

  ////////////////////////////////////////
  // Bus phase FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= SETUP;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    psel      = 1'b0;
    penable   = 1'b0;
    case (state)
      SETUP: begin
        psel = em_mem_enable; // Setup phase lasts exactly one cycle
        if (em_mem_enable) begin
          state_nxt = ACCESS;
        end
      end
      ACCESS: begin
        psel    = 1'b1;
        penable = 1'b1;
        if (pready) begin
          state_nxt = SETUP; // A following memory op gets its setup on the next cycle
        end
      end
      default: begin
        state_nxt = SETUP;
      end
    endcase
  end

  assign done = (state == ACCESS) && pready;

  ////////////////////////////////////////
  // Bus fields and pipeline handshake
  ////////////////////////////////////////

  // EX/MEM holds while stalled, so address, direction and data stay put for free
  assign paddr  = em_alu_out;
  assign pwdata = em_mem_wdata;
  assign pwrite = em_mem_write;

  // The op leaves EX/MEM on the edge that ends its completion cycle
  assign stall = em_mem_enable && !done;

  // MEM/WB only keeps this on the completion edge, when stall is low
  assign rdata = prdata;

  ////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////

  a_penable_in_psel : assert property (@(posedge clk) disable iff (!arst_n)
    penable |-> psel);

  // Until the completer answers, the requester may not change the transfer
  a_stable_transfer : assert property (@(posedge clk) disable iff (!arst_n)
    (psel && !(penable && pready)) |=>
      (psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata)));

  // A transfer is never abandoned before its completion cycle
  a_psel_drop_after_ready : assert property (@(posedge clk) disable iff (!arst_n)
    $fell(psel) |-> $past(penable && pready));

endmodule

`default_nettype wire // Back to the language default for later files

/* mem_wb_pipe_reg.sv */
`default_nettype none // Catch any undeclared net as an error

module mem_wb_pipe_reg import cpu_pkg::*; (
  input  logic     clk,           // Core clock
  input  logic     arst_n,        // Asynchronous reset, active low
  input  logic     stall,         // Memory stage still busy, so send a bubble
  input  word_t    em_pc_next,
  input  word_t    em_alu_out,
  input  reg_idx_t em_reg_rd,
  input  logic     em_reg_write,
  input  logic     em_mem_to_reg,
  input  logic     em_hlt,
  input  logic     em_pcs,
  input  word_t    rdata,         // Load data from the completing transfer
  output word_t    mw_pc_next,
  output word_t    mw_alu_out,
  output word_t    mw_rdata,
  output reg_idx_t mw_reg_rd,
  output logic     mw_reg_write,
  output logic     mw_mem_to_reg,
  output logic     mw_hlt,
  output logic     mw_pcs
);

  ////////////////////////////////////////
  // Control bits
  ////////////////////////////////////////

  // A stalled edge loads a bubble, so an op held in EX/MEM retires only once
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mw_reg_write  <= 1'b0;
      mw_mem_to_reg <= 1'b0;
      mw_hlt        <= 1'b0;
      mw_pcs        <= 1'b0;
    end else begin
      mw_reg_write  <= em_reg_write && !stall; // Bubble never writes a register
      mw_hlt        <= em_hlt && !stall;       // Nor does it halt the core
      mw_mem_to_reg <= em_mem_to_reg;
      mw_pcs        <= em_pcs;
    end
  end

  ////////////////////////////////////////
  // Payload
  ////////////////////////////////////////

  // Payload in a bubble is ignored since its reg_write is low
  always_ff @(posedge clk) begin
    mw_pc_next <= em_pc_next;
    mw_alu_out <= em_alu_out;
    mw_rdata   <= rdata;      // Valid on the completion edge of a load
    mw_reg_rd  <= em_reg_rd;
  end

endmodule

`default_nettype wire // Back to the language default for later files

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cpu_backend -f list.f -o sim_tb \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
! grep -q '\*\*\* FAILED \*\*\*' sim.log && grep -q '\*\*\* PASSED \*\*\*' sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* tb_apb_mem.sv */
module tb_apb_mem import cpu_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  word_t paddr,
  input  word_t pwdata,
  input  logic  pwrite,
  input  logic  psel,
  input  logic  penable,
  output word_t prdata,
  output logic  pready
);

  word_t      mem [256]; // Indexed by the low byte of paddr
  logic [1:0] wait_cnt;  // Wait cycles left in the current access phase

  // Every word gets a value that depends on its whole address
  function automatic word_t fill_word(input logic [7:0] a);
    return {a, ~a} ^ 16'h3c5a;
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(8'(i));
    end
  end

  ////////////////////////////////////////
  // Wait states
  ////////////////////////////////////////

  // A fresh random wait count is drawn in every setup phase
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= 2'd0;
    end else if (psel && !penable) begin
      wait_cnt <= 2'($urandom_range(3, 0)); // Zero to three wait cycles
    end else if (psel && penable && (wait_cnt != 2'd0)) begin
      wait_cnt <= wait_cnt - 2'd1;
    end
  end

  assign pready = psel && penable && (wait_cnt == 2'd0);
  assign prdata = mem[paddr[7:0]]; // Read data is valid whenever the address is

  // Stores land on the completion edge
  always @(posedge clk) begin
    if (psel && penable && pready && pwrite) begin
      mem[paddr[7:0]] <= pwdata;
    end
  end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD       = 10, // Clock period in time units
  parameter int RESET_CYCLES = 4   // Rising edges with reset held low
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset releases a small delay after an edge, like every other testbench input
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

/* tb_cpu_backend.sv */
module tb_cpu_backend import cpu_pkg::*; ();

  localparam int N_INSTR     = 63;               // 16 fill, 40 random, halt, 6 after halt
  localparam int CYCLE_LIMIT = N_INSTR * 6 + 50;
  localparam logic [2:0] K_ALU   = 3'd0;
  localparam logic [2:0] K_PCS   = 3'd1;
  localparam logic [2:0] K_STORE = 3'd2;
  localparam logic [2:0] K_LOAD  = 3'd3;
  localparam logic [2:0] K_HLT   = 3'd4;

  logic clk, arst_n, stall, pwrite, psel, penable, pready, wb_reg_write, halted;
  word_t ex_pc_next, ex_alu_out, ex_mem_wdata, paddr, pwdata, prdata, rf_rdata, wb_data;
  logic ex_mem_enable, ex_mem_write, ex_reg_write, ex_mem_to_reg, ex_hlt, ex_pcs;
  reg_idx_t ex_reg_rd, rf_raddr, wb_reg_rd;

  reg_idx_t exp_rd_a [64];    // Expected retire order
  word_t    exp_data_a [64];
  word_t    exp_addr_a [64];  // Expected APB transfers in order
  logic     exp_wr_a [64];
  word_t    exp_wdata_a [64];
  logic [5:0] n_exp, ret_ptr, n_xfer, xfer_ptr;
  word_t    shadow_mem [256];
  word_t    shadow_rf [16];
  logic     rf_chk;           // A register file read check is due at the next edge
  word_t    rf_exp;
  logic     halt_issued;
  int       cycles;

  tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(4)) i_tb_clock_gen (.clk, .arst_n);

  tb_apb_mem i_tb_apb_mem (
    .clk, .arst_n, .paddr, .pwdata, .pwrite, .psel, .penable, .prdata, .pready
  );

  cpu_backend i_cpu_backend (.*);

  task automatic stop_on_error();
    $display("*** FAILED ***");
    $fatal(1, "Stopping at the first error");
  endtask

  ////////////////////////////////////////
  // Scoreboard pointers and timeout
  ////////////////////////////////////////

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ret_ptr  <= 6'd0;
      xfer_ptr <= 6'd0;
    end else begin
      if (wb_reg_write) ret_ptr <= ret_ptr + 6'd1;          // One retire consumed
      if (psel && penable && pready) xfer_ptr <= xfer_ptr + 6'd1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_on_error();
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_reset_quiet : assert property (@(posedge clk) (!arst_n || $past(!arst_n)) |->
    (!psel && !penable && !stall && !wb_reg_write && !halted))
    else begin
      $display("** Error: psel=%h penable=%h stall=%h wb_reg_write=%h halted=%h, expected all 0",
        $sampled(psel), $sampled(penable), $sampled(stall), $sampled(wb_reg_write),
        $sampled(halted));
      stop_on_error();
    end

  // Stall covers exactly the part of a transfer before its pready cycle
  a_stall_window : assert property (@(posedge clk) disable iff (!arst_n)
    stall == (psel && !(penable && pready)))
    else begin
      $display("** Error: stall = %h, expected %h", $sampled(stall),
        $sampled(psel && !(penable && pready)));
      stop_on_error();
    end

  a_retire_match : assert property (@(posedge clk) disable iff (!arst_n)
    wb_reg_write |-> (ret_ptr < n_exp && wb_reg_rd == exp_rd_a[ret_ptr] &&
                      wb_data == exp_data_a[ret_ptr]))
    else begin
      $display(
        "** Error: wb_reg_rd = %h, expected %h; wb_data = %h, expected %h (retire %0d of %0d)",
        $sampled(wb_reg_rd), exp_rd_a[$sampled(ret_ptr)], $sampled(wb_data),
        exp_data_a[$sampled(ret_ptr)], $sampled(ret_ptr), $sampled(n_exp));
      stop_on_error();
    end

  a_xfer_match : assert property (@(posedge clk) disable iff (!arst_n)
    (psel && penable && pready) |-> (xfer_ptr < n_xfer && paddr == exp_addr_a[xfer_ptr] &&
      pwrite == exp_wr_a[xfer_ptr] && (!pwrite || pwdata == exp_wdata_a[xfer_ptr])))
    else begin
      $display(
        "** Error: paddr = %h, expected %h; pwrite = %h, expected %h; pwdata = %h, expected %h",
        $sampled(paddr), exp_addr_a[$sampled(xfer_ptr)], $sampled(pwrite),
        exp_wr_a[$sampled(xfer_ptr)], $sampled(pwdata), exp_wdata_a[$sampled(xfer_ptr)]);
      stop_on_error();
    end

  a_rf_read : assert property (@(posedge clk) disable iff (!arst_n)
    rf_chk |-> (rf_rdata == rf_exp))
    else begin
      $display("** Error: rf_rdata = %h, expected %h (rf_raddr = %h)",
        $sampled(rf_rdata), $sampled(rf_exp), $sampled(rf_raddr));
      stop_on_error();
    end

  a_halt_final : assert property (@(posedge clk) disable iff (!arst_n)
    halted |-> (!wb_reg_write ##1 halted))
    else begin
      $display("Halt check: halted fell or a register write retired after the halt");
      stop_on_error();
    end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic idle_inputs();
    {ex_pc_next, ex_alu_out, ex_mem_wdata} = '0;
    {ex_mem_enable, ex_mem_write, ex_reg_write, ex_mem_to_reg, ex_hlt, ex_pcs} = '0;
    ex_reg_rd = '0;
  endtask

  // Drives one instruction and returns one unit after the edge that captured it
  task automatic issue(input logic [2:0] kind, input reg_idx_t rd);
    word_t pc, alu, wd, data;
    logic [7:0] a;
    pc  = 16'($urandom);
    alu = 16'($urandom);
    wd  = 16'($urandom);
    if (kind == K_STORE || kind == K_LOAD) alu = 16'h0040 + 16'($urandom_range(15, 0));
    a = alu[7:0]; // Small address window so loads see earlier stores
    ex_pc_next    = pc;
    ex_alu_out    = alu;
    ex_mem_wdata  = wd;
    ex_mem_enable = (kind == K_STORE) || (kind == K_LOAD);
    ex_mem_write  = (kind == K_STORE);
    ex_reg_rd     = rd;
    ex_reg_write  = (kind == K_ALU) || (kind == K_PCS) || (kind == K_LOAD);
    ex_mem_to_reg = (kind == K_LOAD);
    ex_hlt        = (kind == K_HLT);
    ex_pcs        = (kind == K_PCS);
    if (ex_mem_enable) begin
      exp_addr_a[n_xfer]  = alu;
      exp_wr_a[n_xfer]    = ex_mem_write;
      exp_wdata_a[n_xfer] = wd;
      n_xfer = n_xfer + 6'd1;
    end
    if (kind == K_LOAD) data = shadow_mem[a];  // Last stored value at this address
    else if (kind == K_PCS) data = pc;
    else data = alu;
    if (kind == K_STORE) shadow_mem[a] = wd;
    if (ex_reg_write && !halt_issued) begin
      exp_rd_a[n_exp]   = rd;
      exp_data_a[n_exp] = data;
      n_exp = n_exp + 6'd1;
      if (rd != '0) shadow_rf[rd] = data; // r0 keeps reading zero
    end
    if (kind == K_HLT) halt_issued = 1'b1;
    do @(negedge clk); while (stall); // Inputs hold until the register takes them
    @(posedge clk);
    #1;
  endtask

  task automatic sweep_regs();
    reg_idx_t r;
    r = '0;
    repeat (16) begin
      rf_raddr = r;
      rf_exp   = shadow_rf[r];
      rf_chk   = 1'b1;
      @(posedge clk);
      #1;
      r = r + 4'd1;
    end
    rf_chk = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h8d4406d7));
    idle_inputs();
    rf_raddr    = '0;
    rf_chk      = 1'b0;
    rf_exp      = '0;
    n_exp       = '0;
    n_xfer      = '0;
    halt_issued = 1'b0;
    cycles      = 0;
    for (int i = 0; i < 256; i++) begin
      shadow_mem[i] = {8'(i), ~8'(i)} ^ 16'h3c5a; // Same fill rule as the completer model
    end
    for (int i = 0; i < 16; i++) shadow_rf[i] = '0;
    wait (arst_n);
    @(posedge clk);
    #1;
    // Every register gets a known value, and r0 takes a write that must not land
    for (int i = 0; i < 16; i++) issue(K_ALU, 4'(i));
    repeat (40) issue(3'($urandom_range(3, 0)), 4'($urandom));
    idle_inputs();
    while (ret_ptr != n_exp) begin
      @(posedge clk);
      #1;
    end
    sweep_regs();
    issue(K_HLT, '0);
    repeat (6) issue(K_ALU, 4'($urandom)); // These must never land
    idle_inputs();
    while (!halted) begin
      @(posedge clk);
      #1;
    end
    repeat (3) @(posedge clk);
    #1;
    sweep_regs();
    if (ret_ptr == n_exp && xfer_ptr == n_xfer) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Count check: %0d of %0d retires and %0d of %0d transfers seen",
        ret_ptr, n_exp, xfer_ptr, n_xfer);
      stop_on_error();
    end
  end

endmodule

/* write_back.sv */
`default_nettype none // Catch any undeclared net as an error

`include "cpu_config.svh"

module write_back import cpu_pkg::*; (
  input  logic     clk,           // Core clock
  input  logic     arst_n,        // Asynchronous reset, active low
  input  word_t    mw_pc_next,
  input  word_t    mw_alu_out,
  input  word_t    mw_rdata,
  input  reg_idx_t mw_reg_rd,
  input  logic     mw_reg_write,
  input  logic     mw_mem_to_reg,
  input  logic     mw_hlt,
  input  logic     mw_pcs,
  input  reg_idx_t rf_raddr,      // Register file read address
  output word_t    rf_rdata,      // Read data, available in the same cycle
  output logic     wb_reg_write,  // Retire write strobe
  output reg_idx_t wb_reg_rd,     // Retire destination register
  output word_t    wb_data,       // Retire write data
  output logic     halted         // Core has retired a halt
);

  word_t rf [`CPU_NUM_REGS]; // Entry 0 is never written

  ////////////////////////////////////////
  // Result select and retire port
  ////////////////////////////////////////

  always_comb begin
    if (mw_mem_to_reg) begin
      wb_data = mw_rdata;    // Load result
    end else if (mw_pcs) begin
      wb_data = mw_pc_next;  // Link value for PCS
    end else begin
      wb_data = mw_alu_out;  // Plain ALU result
    end
  end

  assign wb_reg_rd    = mw_reg_rd;
  assign wb_reg_write = mw_reg_write && !halted; // Nothing retires once halted

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  // A write to r0 still shows on the retire port but does not land in the array
  always_ff @(posedge clk) begin
    if (wb_reg_write && (wb_reg_rd != '0)) begin
      rf[wb_reg_rd] <= wb_data;
    end
  end

  assign rf_rdata = (rf_raddr == '0) ? '0 : rf[rf_raddr]; // r0 reads as zero

  // Halt is sticky until the next reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halted <= 1'b0;
    end else if (mw_hlt) begin
      halted <= 1'b1;
    end
  end

  // Once halted, the core stays halted and never writes a register again
  a_halt_is_final : assert property (@(posedge clk) disable iff (!arst_n)
    halted |=> (halted && !wb_reg_write));

endmodule

`default_nettype wire // Back to the language default for later files
